// ==== test/display_input.mem ====
// Tag nibble first. 1:0AAAADD mem, 2:R00VVVV reg (0 dmactl 1 chbase 2 nmien 3 dlist)
// 3:vblank rise cycle, 4:00000KVV expected kind/byte, 5:expected nmist, 6:0CCCCVV nmien at cycle
20000021 210000E0 22000040 23002000 300005DC 600578C0
10200080 10200170 10200248 10200300 10200430 10200501 10200620 10200720
10202046 10202180 102022C0 10202341 10202400 10202521
10210080 10210141 10210200 10210321
40000080 40000070 40000048 40000100 40000130
40000230 40000231 40000232 40000233 40000234 40000235 40000236 40000237
40000001 40000120 40000120 40000046 40000180 400001C0
40000240 400003E0 400003E1 400003E2 400003E3 400003E4 400003E5 400003E6 400003E7
40000241 400003E8 400003E9 400003EA 400003EB 400003EC 400003ED 400003EE 400003EF
40000242 400003F0 400003F1 400003F2 400003F3 400003F4 400003F5 400003F6 400003F7
40000243 400003F8 400003F9 400003FA 400003FB 400003FC 400003FD 400003FE 400003FF
40000244 400003C0 400003C1 400003C2 400003C3 400003C4 400003C5 400003C6 400003C7
40000245 400003C8 400003C9 400003CA 400003CB 400003CC 400003CD 400003CE 400003CF
40000246 400003D0 400003D1 400003D2 400003D3 400003D4 400003D5 400003D6 400003D7
40000247 400003D8 400003D9 400003DA 400003DB 400003DC 400003DD 400003DE 400003DF
40000248 400003A0 400003A1 400003A2 400003A3 400003A4 400003A5 400003A6 400003A7
40000249 400003A8 400003A9 400003AA 400003AB 400003AC 400003AD 400003AE 400003AF
4000024A 400003B0 400003B1 400003B2 400003B3 400003B4 400003B5 400003B6 400003B7
4000024B 400003B8 400003B9 400003BA 400003BB 400003BC 400003BD 400003BE 400003BF
4000024C 40000380 40000381 40000382 40000383 40000384 40000385 40000386 40000387
4000024D 40000388 40000389 4000038A 4000038B 4000038C 4000038D 4000038E 4000038F
4000024E 40000390 40000391 40000392 40000393 40000394 40000395 40000396 40000397
4000024F 40000398 40000399 4000039A 4000039B 4000039C 4000039D 4000039E 4000039F
40000041 40000100 40000121
40000080 40000041 40000100 40000121
50000040 50000080
00000000

// ==== src.f ====
logic/anticPkg.sv
logic/instrDecoder.sv
logic/scanCounters.sv
logic/dmaSequencer.sv
logic/nmiGen.sv
logic/antic.sv
test/clockGen.sv
test/antic_asserts.sv
test/anticTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module anticTb -f src.f
	@out=$$(./obj_dir/VanticTb); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== test/anticTb.sv ====
// Display list DMA testbench
`default_nettype none

module anticTb;
  timeunit 1ns;
  timeprecision 100ps;
  import anticPkg::*;

  localparam int MaxRecs = 512;

  logic Fphi0, rst, rdy, vblank, halt, dataValid, nmiL;
  byteT db, dmactl, chbase, nmien, dataOut, nmist;
  addrT dlistStart, address;
  kindT dataKind;

  logic [31:0] recs [MaxRecs];
  byteT memImg [65536];
  logic [31:0] expStream [$];
  byteT expNmist [$];
  int vblTimes [$];
  logic [31:0] nmienSets [$];
  int cycle, seed, valueErrs, streamErrs, expIdx, nmiIdx;
  logic loaded, nmiPrev, haltPrev;

  clockGen clk (.Fphi0(Fphi0), .rst(rst));

  antic #(.GlyphRows(GlyphRowsDef)) DUT (
    .Fphi0(Fphi0), .rst(rst), .rdy(rdy), .vblank(vblank), .db(db),
    .dmactl(dmactl), .chbase(chbase), .nmien(nmien), .dlistStart(dlistStart),
    .halt(halt), .address(address), .dataOut(dataOut), .dataKind(dataKind),
    .dataValid(dataValid), .nmiL(nmiL), .nmist(nmist)
  );

  // Memory answers combinationally
  assign db = memImg[address];

  task automatic loadImage();
    logic [31:0] rec;
    for (int a = 0; a < 65536; a++) begin
      memImg[a] = byteT'(a[15:8] ^ a[7:0]);
    end
    for (int i = 0; i < MaxRecs; i++) begin
      recs[i] = '0;
    end
    $readmemh("test/display_input.mem", recs);
    for (int i = 0; i < MaxRecs; i++) begin
      rec = recs[i];
      case (rec[31:28])
        4'h1: memImg[rec[23:8]] = rec[7:0];
        4'h2: begin
          case (rec[27:24])
            4'h0: dmactl = rec[7:0];
            4'h1: chbase = rec[7:0];
            4'h2: nmien = rec[7:0];
            default: dlistStart = rec[15:0];
          endcase
        end
        4'h3: vblTimes.push_back(int'(rec[23:0]));
        4'h4: expStream.push_back(rec);
        4'h5: expNmist.push_back(rec[7:0]);
        4'h6: nmienSets.push_back(rec);
        default: ;
      endcase
    end
  endtask

  task automatic checkByte(input byteT got, input byteT exp, input int idx);
    if (got !== exp) begin
      valueErrs++;
      $display("** Error at %0t: record %0d byte %02h, expected %02h", $time, idx, got, exp);
    end
  endtask

  task automatic checkKind(input kindT got, input kindT exp, input int idx);
    if (got !== exp) begin
      valueErrs++;
      $display("** Error at %0t: record %0d kind %0d, expected %0d", $time, idx, got, exp);
    end
  endtask

  task automatic checkNmist(input byteT got, input byteT exp, input int idx);
    if (got !== exp) begin
      valueErrs++;
      $display("** Error at %0t: NMI %0d nmist %02h, expected %02h", $time, idx, got, exp);
    end
  endtask

  always @(posedge Fphi0) begin
    cycle <= cycle + 1;
  end

  // Stimulus on the falling edge
  always @(negedge Fphi0) begin
    if (loaded) begin
      rdy <= ($unsigned($random(seed)) % 100) < 70;
      foreach (vblTimes[i]) begin
        if (cycle == vblTimes[i]) begin
          vblank <= 1'b1;
        end
        if (cycle == vblTimes[i] + 20) begin
          vblank <= 1'b0;
        end
      end
      foreach (nmienSets[i]) begin
        if (cycle == int'(nmienSets[i][23:8])) begin
          nmien <= nmienSets[i][7:0];
        end
      end
    end
  end

  // Output monitor, sampled mid-cycle
  always @(negedge Fphi0) begin
    if (!rst) begin
      if (dataValid) begin
        if (expIdx >= expStream.size()) begin
          streamErrs++;
          $display("Unexpected extra record kind %0d byte %02h at %0t", dataKind, dataOut, $time);
        end else begin
          checkKind(dataKind, kindT'(expStream[expIdx][9:8]), expIdx);
          checkByte(dataOut, expStream[expIdx][7:0], expIdx);
        end
        expIdx++;
      end
      // A record follows only an edge with halt and rdy both high
      if (dataValid !== (haltPrev && rdy)) begin
        streamErrs++;
        $display("Handshake broken: dataValid %0b after halt %0b and rdy %0b at %0t",
                 dataValid, haltPrev, rdy, $time);
      end
      haltPrev = halt;
      if (nmiPrev && !nmiL) begin
        if (nmiIdx >= expNmist.size()) begin
          streamErrs++;
          $display("Unexpected NMI pulse with nmist %02h at %0t", nmist, $time);
        end else begin
          checkNmist(nmist, expNmist[nmiIdx], nmiIdx);
        end
        nmiIdx++;
      end
      nmiPrev = nmiL;
    end
  end

  initial begin
    seed = 17;
    cycle = 0;
    loaded = 1'b0;
    valueErrs = 0;
    streamErrs = 0;
    expIdx = 0;
    nmiIdx = 0;
    nmiPrev = 1'b1;
    haltPrev = 1'b0;
    rdy = 1'b0;
    vblank = 1'b0;
    dmactl = '0;
    chbase = '0;
    nmien = '0;
    dlistStart = '0;
    loadImage();
    loaded = 1'b1;
    while (rst) @(posedge Fphi0);
    while (expIdx < expStream.size() || nmiIdx < expNmist.size()) @(posedge Fphi0);
    // Time for any stray record to show up
    repeat (200) @(posedge Fphi0);
    $display("Errors: %0d value, %0d stream, %0d assertion", valueErrs, streamErrs,
             DUT.handshakeChecks.failCount);
    if (valueErrs + streamErrs + DUT.handshakeChecks.failCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    while (!loaded) @(posedge Fphi0);
    repeat (40 * expStream.size() + 2000) @(posedge Fphi0);
    $display("Watchdog expired with %0d of %0d records and %0d of %0d NMIs seen",
             expIdx, expStream.size(), nmiIdx, expNmist.size());
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/antic_asserts.sv ====
// DMA handshake and NMI assertions
`default_nettype none

module anticAsserts (
  input logic Fphi0,
  input logic rst,
  input logic rdy,
  input logic halt,
  input anticPkg::addrT address,
  input logic nmiL
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // Back-pressure freezes the bus side
  stallHold: assert property (@(posedge Fphi0) disable iff (rst)
    !rdy |=> $stable(address) && $stable(halt))
    else begin
      $error("address or halt moved while rdy was low");
      failCount++;
    end

  nmiWidth: assert property (@(posedge Fphi0) disable iff (rst)
    $fell(nmiL) |=> !nmiL ##1 nmiL)
    else begin
      $error("nmiL low pulse was not exactly two cycles");
      failCount++;
    end

  haltAfterReset: assert property (@(posedge Fphi0) $fell(rst) |-> !halt)
    else begin
      $error("halt was high right after reset");
      failCount++;
    end

endmodule

bind antic anticAsserts handshakeChecks (
  .Fphi0(Fphi0), .rst(rst), .rdy(rdy), .halt(halt), .address(address), .nmiL(nmiL)
);

`default_nettype wire

// ==== test/clockGen.sv ====
// Testbench clock and reset
`default_nettype none

module clockGen #(
  parameter int HalfPeriod = 4,
  parameter int ResetCycles = 4
) (
  output logic Fphi0,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    Fphi0 = 1'b0;
    forever #(HalfPeriod) Fphi0 = ~Fphi0;
  end

  initial begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge Fphi0);
    @(negedge Fphi0);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== logic/antic.sv ====
// ANTIC display list DMA engine
`default_nettype none

module antic #(
  parameter int GlyphRows = anticPkg::GlyphRowsDef
) (
  input  logic Fphi0,
  input  logic rst,
  input  logic rdy,
  input  logic vblank,
  input  anticPkg::byteT db,
  input  anticPkg::byteT dmactl,
  input  anticPkg::byteT chbase,
  input  anticPkg::byteT nmien,
  input  anticPkg::addrT dlistStart,
  output logic halt,
  output anticPkg::addrT address,
  output anticPkg::byteT dataOut,
  output anticPkg::kindT dataKind,
  output logic dataValid,
  output logic nmiL,
  output anticPkg::byteT nmist
);
  import anticPkg::*;

  dlInstrT instr;
  addrT dlPtr;
  addrT msr;
  byteT lineBytes;
  logic isBlank, isJump, waitVbl, hasLms, isChar, singleColor;
  logic dlInc, msrInc, opLoadLo, opLoadHi, opTarget, restart, dliReq;

  dmaSequencer #(.GlyphRows(GlyphRows)) sequencer (
    .Fphi0(Fphi0), .rst(rst), .rdy(rdy), .vblank(vblank), .dmaEnable(dmactl[5]),
    .db(db), .chbase(chbase), .dlPtr(dlPtr), .msr(msr),
    .isBlank(isBlank), .isJump(isJump), .waitVbl(waitVbl), .hasLms(hasLms),
    .isChar(isChar), .singleColor(singleColor), .lineBytes(lineBytes),
    .instr(instr), .halt(halt), .address(address),
    .dataOut(dataOut), .dataKind(dataKind), .dataValid(dataValid),
    .dlInc(dlInc), .msrInc(msrInc), .opLoadLo(opLoadLo), .opLoadHi(opLoadHi),
    .opTarget(opTarget), .restart(restart), .dliReq(dliReq)
  );

  instrDecoder decoder (
    .instr(instr), .widthSel(dmactl[1:0]),
    .isBlank(isBlank), .isJump(isJump), .waitVbl(waitVbl), .hasLms(hasLms),
    .isChar(isChar), .singleColor(singleColor), .lineBytes(lineBytes)
  );

  scanCounters counters (
    .Fphi0(Fphi0), .rst(rst), .dlistStart(dlistStart), .db(db),
    .dlInc(dlInc), .msrInc(msrInc), .opLoadLo(opLoadLo), .opLoadHi(opLoadHi),
    .opTarget(opTarget), .restart(restart), .dlPtr(dlPtr), .msr(msr)
  );

  nmiGen nmi (
    .Fphi0(Fphi0), .rst(rst), .dliReq(dliReq), .vblank(vblank),
    .nmien(nmien), .nmiL(nmiL), .nmist(nmist)
  );

endmodule

`default_nettype wire

// ==== logic/nmiGen.sv ====
// DLI and VBI interrupt generator
`default_nettype none

module nmiGen (
  input  logic Fphi0,
  input  logic rst,
  input  logic dliReq,
  input  logic vblank,
  input  anticPkg::byteT nmien,
  output logic nmiL,
  output anticPkg::byteT nmist
);

  logic vblankQ;
  logic dliHit;
  logic vbiHit;
  logic holdLow;

  assign dliHit = dliReq & nmien[7];
  assign vbiHit = vblank & ~vblankQ & nmien[6];

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      vblankQ <= 1'b0;
      nmiL <= 1'b1;
      holdLow <= 1'b0;
      nmist <= '0;
    end else begin
      vblankQ <= vblank;
      if (dliHit || vbiHit) begin
        nmist <= {dliHit, vbiHit, 6'b000000};
      end
      // Two cycle low pulse, later hits only touch status
      if (nmiL) begin
        if (dliHit || vbiHit) begin
          nmiL <= 1'b0;
          holdLow <= 1'b1;
        end
      end else if (holdLow) begin
        holdLow <= 1'b0;
      end else begin
        nmiL <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/dmaSequencer.sv ====
// DMA sequencer for display list, screen and glyph fetches
`default_nettype none

module dmaSequencer #(
  parameter int GlyphRows = anticPkg::GlyphRowsDef
) (
  input  logic Fphi0,
  input  logic rst,
  input  logic rdy,
  input  logic vblank,
  input  logic dmaEnable,
  input  anticPkg::byteT db,
  input  anticPkg::byteT chbase,
  input  anticPkg::addrT dlPtr,
  input  anticPkg::addrT msr,
  input  logic isBlank,
  input  logic isJump,
  input  logic waitVbl,
  input  logic hasLms,
  input  logic isChar,
  input  logic singleColor,
  input  anticPkg::byteT lineBytes,
  output anticPkg::dlInstrT instr,
  output logic halt,
  output anticPkg::addrT address,
  output anticPkg::byteT dataOut,
  output anticPkg::kindT dataKind,
  output logic dataValid,
  output logic dlInc,
  output logic msrInc,
  output logic opLoadLo,
  output logic opLoadHi,
  output logic opTarget,
  output logic restart,
  output logic dliReq
);
  import anticPkg::*;

  localparam logic [2:0] StIdle = 3'd0;
  localparam logic [2:0] StInstr = 3'd1;
  localparam logic [2:0] StDecode = 3'd2;
  localparam logic [2:0] StOperand = 3'd3;
  localparam logic [2:0] StWaitVbl = 3'd4;
  localparam logic [2:0] StScreen = 3'd5;
  localparam logic [2:0] StGlyph = 3'd6;

  logic [2:0] state;
  logic xfer;
  logic xferNow;
  logic opCnt;
  logic vblankQ;
  logic vblPend;
  byteT byteCnt;
  byteT code;
  byteT row;
  addrT glyphAddr;
  kindT kindNow;

  // xfer marks the transfer cycle; the cycle before it puts out the address
  assign halt = xfer;
  assign xferNow = xfer & rdy;

  assign glyphAddr = {chbase, 8'h00} + addrT'(code) * addrT'(GlyphRows) + addrT'(row);

  always_comb begin
    case (state)
      StScreen: address = msr;
      StGlyph: address = glyphAddr;
      default: address = dlPtr;
    endcase
  end

  always_comb begin
    case (state)
      StOperand: kindNow = KindOperand;
      StScreen: kindNow = KindScreen;
      StGlyph: kindNow = KindGlyph;
      default: kindNow = KindInstr;
    endcase
  end

  // Counter strobes land on the transfer edge
  assign dlInc = xferNow && (state == StInstr || (state == StOperand && !(opCnt && isJump)));
  assign msrInc = xferNow && state == StScreen;
  assign opLoadLo = xferNow && state == StOperand && !opCnt;
  assign opLoadHi = xferNow && state == StOperand && opCnt;
  assign opTarget = !isJump;
  assign restart = rdy && !xfer && state == StIdle && dmaEnable;
  assign dliReq = rdy && state == StDecode && instr.ctrl.dli;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state <= StIdle;
      xfer <= 1'b0;
      opCnt <= 1'b0;
      byteCnt <= '0;
      row <= '0;
      vblankQ <= 1'b0;
      vblPend <= 1'b0;
      dataValid <= 1'b0;
      instr <= '0;
    end else begin
      dataValid <= xferNow;
      vblankQ <= vblank;
      if (vblank && !vblankQ) begin
        vblPend <= 1'b1;
      end
      if (rdy && !xfer) begin
        case (state)
          StIdle: begin
            if (dmaEnable) begin
              state <= StInstr;
            end
          end
          StInstr: begin
            if (dmaEnable) begin
              xfer <= 1'b1;
            end else begin
              state <= StIdle;
            end
          end
          StDecode: begin
            byteCnt <= '0;
            if (isJump || hasLms) begin
              state <= StOperand;
            end else if (isBlank || lineBytes == 8'd0) begin
              state <= StInstr;
            end else begin
              state <= StScreen;
            end
          end
          StWaitVbl: begin
            if (vblPend) begin
              vblPend <= 1'b0;
              state <= StInstr;
            end
          end
          default: xfer <= 1'b1;
        endcase
      end else if (xferNow) begin
        xfer <= 1'b0;
        case (state)
          StInstr: begin
            instr <= db;
            state <= StDecode;
          end
          StOperand: begin
            opCnt <= !opCnt;
            if (opCnt && isJump) begin
              // Only an edge after the jump releases JVB
              vblPend <= 1'b0;
              state <= waitVbl ? StWaitVbl : StInstr;
            end else if (opCnt) begin
              state <= (lineBytes == 8'd0) ? StInstr : StScreen;
            end
          end
          StScreen: begin
            byteCnt <= byteCnt + 8'd1;
            row <= '0;
            if (isChar) begin
              state <= StGlyph;
            end else if (byteCnt + 8'd1 == lineBytes) begin
              state <= StInstr;
            end
          end
          default: begin
            row <= row + 8'd1;
            if (row == byteT'(GlyphRows - 1)) begin
              state <= (byteCnt == lineBytes) ? StInstr : StScreen;
            end
          end
        endcase
      end
    end
  end

  // Byte stream and the character code for glyph lookup
  always_ff @(posedge Fphi0) begin
    if (xferNow) begin
      dataOut <= db;
      dataKind <= kindNow;
    end
    if (xferNow && state == StScreen) begin
      code <= singleColor ? {2'b00, db[5:0]} : db;
    end
  end

endmodule

`default_nettype wire

// ==== logic/scanCounters.sv ====
// Display list and memory scan counters
`default_nettype none

module scanCounters (
  input  logic Fphi0,
  input  logic rst,
  input  anticPkg::addrT dlistStart,
  input  anticPkg::byteT db,
  input  logic dlInc,
  input  logic msrInc,
  input  logic opLoadLo,
  input  logic opLoadHi,
  input  logic opTarget,
  input  logic restart,
  output anticPkg::addrT dlPtr,
  output anticPkg::addrT msr
);
  import anticPkg::*;

  byteT opLow;

  // opTarget high selects the scan counter (LMS)
  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      dlPtr <= dlistStart;
      msr <= '0;
    end else begin
      if (restart) begin
        dlPtr <= dlistStart;
      end else if (opLoadHi && !opTarget) begin
        dlPtr <= {db, opLow};
      end else if (dlInc) begin
        dlPtr <= dlPtr + 16'd1;
      end

      if (opLoadHi && opTarget) begin
        msr <= {db, opLow};
      end else if (msrInc) begin
        msr <= msr + 16'd1;
      end
    end
  end

  // Low operand byte waits for its high half
  always_ff @(posedge Fphi0) begin
    if (opLoadLo) begin
      opLow <= db;
    end
  end

endmodule

`default_nettype wire

// ==== logic/instrDecoder.sv ====
// Display list instruction decode
`default_nettype none

module instrDecoder (
  input  anticPkg::dlInstrT instr,
  input  logic [1:0] widthSel,
  output logic isBlank,
  output logic isJump,
  output logic waitVbl,
  output logic hasLms,
  output logic isChar,
  output logic singleColor,
  output anticPkg::byteT lineBytes
);
  import anticPkg::*;

  logic isCtrl;
  logic [3:0] modeNum;

  // Low nibble 0 or 1 means blank or jump
  assign isBlank = instr.ctrl.low == LowBlank;
  assign isJump = instr.ctrl.low == LowJump;
  assign isCtrl = isBlank || isJump;

  // JVB when bit 6 is set
  assign waitVbl = isJump && instr.ctrl.count[2];

  assign modeNum = instr.mode.modeNum;
  assign hasLms = !isCtrl && instr.mode.lms;

  // Text modes 2 to 7, modes 6 and 7 one colour per glyph
  assign isChar = !isCtrl && modeNum >= 4'h2 && modeNum <= 4'h7;
  assign singleColor = !isCtrl && modeNum[3:1] == 3'b011;

  assign lineBytes = isCtrl ? 8'd0 : BytesPerLine(modeNum, widthSel);

endmodule

`default_nettype wire

// ==== logic/anticPkg.sv ====
// Display list DMA shared types
`default_nettype none

package anticPkg;

  localparam int AddrW = 16;
  localparam int GlyphRowsDef = 8;

  typedef logic [AddrW-1:0] addrT;
  typedef logic [7:0] byteT;

  // Output stream tags
  typedef logic [1:0] kindT;
  localparam kindT KindInstr = 2'd0;
  localparam kindT KindOperand = 2'd1;
  localparam kindT KindScreen = 2'd2;
  localparam kindT KindGlyph = 2'd3;

  // Low nibble opcodes in the ctrl view
  localparam logic [3:0] LowBlank = 4'h0;
  localparam logic [3:0] LowJump = 4'h1;

  // One display list byte, seen as a mode line or as blank/jump
  typedef union packed {
    struct packed {
      logic dli;
      logic lms;
      logic [1:0] scroll;
      logic [3:0] modeNum;
    } mode;
    struct packed {
      logic dli;
      logic [2:0] count;
      logic [3:0] low;
    } ctrl;
  } dlInstrT;

  // Width 01 narrow, 10 normal, 11 wide
  function automatic byteT BytesPerLine(input logic [3:0] modeNum, input logic [1:0] width);
    byteT normal;
    case (modeNum)
      4'h2, 4'h3, 4'h4, 4'h5, 4'hD, 4'hE, 4'hF: normal = 8'd40;
      4'h6, 4'h7, 4'hA, 4'hB, 4'hC: normal = 8'd20;
      4'h8, 4'h9: normal = 8'd10;
      default: normal = 8'd0;
    endcase
    case (width)
      2'b01: return byteT'((normal * 4) / 5);
      2'b10: return normal;
      2'b11: return byteT'((normal * 6) / 5);
      default: return 8'd0;
    endcase
  endfunction

endpackage

`default_nettype wire
